// File: egress_sched.f
sched_cfg_pkg.sv
sched_types_pkg.sv
port_scheduler.sv
port_backlog.sv
slot_grant.sv
egress_sched.sv
egress_sched_tb.sv

// File: egress_sched.sv
`timescale 1ns/1ps

module egress_sched #(
	parameter int BACKLOG_W = 4	// Depth of each port's packet count
) (
	input  logic clk,
	input  logic rst_n,
	input  logic en,	// Wheel runs while high
	input  logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] enq,

	output logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] grant,
	output logic [sched_cfg_pkg::PORT_ID_W-1:0] grant_port_id,
	output logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] drop,
	output logic [1:0] rot_cnt,
	output logic [15:0] unused_slots
);

	logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] sel_port;
	logic [sched_cfg_pkg::PORT_ID_W-1:0] sel_port_id;
	logic slot_valid;
	logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] nonempty;
	logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] deq;

	// Slot wheel, 40 slots per turn
	port_scheduler u_sched (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.rot_cnt    (rot_cnt),
		.sel_port   (sel_port),
		.sel_port_id(sel_port_id),
		.slot_valid (slot_valid)
	);

	port_backlog #(
		.BACKLOG_W(BACKLOG_W)
	) u_backlog (
		.clk     (clk),
		.rst_n   (rst_n),
		.enq     (enq),
		.deq     (deq),
		.nonempty(nonempty),
		.drop    (drop)
	);

	// en to grant is two cycles
	slot_grant u_grant (
		.clk          (clk),
		.rst_n        (rst_n),
		.slot_valid   (slot_valid),
		.sel_port     (sel_port),
		.sel_port_id  (sel_port_id),
		.nonempty     (nonempty),
		.deq          (deq),
		.grant        (grant),
		.grant_port_id(grant_port_id),
		.unused_slots (unused_slots)
	);

endmodule

// File: egress_sched_tb.sv
`timescale 1ns/1ps

module egress_sched_tb;

	localparam int NP = sched_cfg_pkg::NUM_OF_PORTS;
	localparam int BACKLOG_W = 4;
	localparam int FULL = (1 << BACKLOG_W) - 1;	// Saturated counter value
	localparam int CLK_PERIOD = 100;

	// Cycles per phase, the watchdog is sized from their sum
	localparam int RST_CYC = 4;
	localparam int IDLE_CYC = 10;
	localparam int FILL_CYC = 16;
	localparam int FULL_CYC = 80;	// Two wheel turns
	localparam int SPARSE_CYC = 120;
	localparam int TOGGLE_CYC = 160;
	localparam int DROP_CYC = 20 + 45;
	localparam int TOTAL_CYC = RST_CYC + IDLE_CYC + FILL_CYC + FULL_CYC + 4 + SPARSE_CYC
		+ TOGGLE_CYC + DROP_CYC + 8;
	localparam int TIMEOUT_NS = (TOTAL_CYC + 100) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic en;
	logic [NP-1:0] enq;
	logic [NP-1:0] grant;
	logic [sched_cfg_pkg::PORT_ID_W-1:0] grant_port_id;
	logic [NP-1:0] drop;
	logic [1:0] rot_cnt;
	logic [15:0] unused_slots;

	integer seed;
	string test_name;
	int error_count;
	int tally [NP];	// Grants seen per port
	int per_turn [NP] = '{10, 10, 5, 5, 5, 4, 1};	// Slots per 40-slot turn

	// Model state, mirrors what the outputs should show after the last edge
	int m_rot;
	int m_grp;
	int m_sel_id;
	logic [NP-1:0] m_sel;
	logic m_valid;
	int m_cnt [NP];
	logic [NP-1:0] m_drop;
	logic [NP-1:0] m_grant;
	int m_gid;
	logic [15:0] m_unused;
	sched_types_pkg::grant_state_e m_state;

	egress_sched #(
		.BACKLOG_W(BACKLOG_W)
	) dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.en           (en),
		.enq          (enq),
		.grant        (grant),
		.grant_port_id(grant_port_id),
		.drop         (drop),
		.rot_cnt      (rot_cnt),
		.unused_slots (unused_slots)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Port served by the slot at the advanced rotation and group values
	function automatic int slot_port(input int rot_next, input int grp_next);
		int step;
		sched_types_pkg::port_kind_e kind;
		step = (4 - rot_next) % 4;
		if (step < 2)
			kind = sched_types_pkg::PK_10G;
		else if (step == 3 && grp_next == sched_cfg_pkg::LAST_DMA)
			kind = sched_types_pkg::PK_OAM;	// Odd slot of the last group
		else
			kind = sched_types_pkg::PK_DMA;
		case (kind)
			sched_types_pkg::PK_10G: return step;
			sched_types_pkg::PK_OAM: return sched_cfg_pkg::OAM_PORT;
			default: begin
				if (step == 2)
					return (grp_next % 2) ? 3 : 2;
				return (grp_next % 2) ? 5 : 4;
			end
		endcase
	endfunction

	task automatic model_reset();
		m_rot = 0;
		m_grp = 0;
		m_sel_id = 0;
		m_sel = '0;
		m_valid = 1'b0;
		m_drop = '0;
		m_grant = '0;
		m_gid = 0;
		m_unused = 16'd0;
		m_state = sched_types_pkg::GS_IDLE;
		for (int p = 0; p < NP; p++)
			m_cnt[p] = 0;
	endtask

	// One clock edge of the model, inputs as driven on the last falling edge
	task automatic model_step();
		logic [NP-1:0] deq;
		logic hit;
		int rot_n;
		int grp_n;
		hit = m_valid && (m_cnt[m_sel_id] != 0);
		deq = '0;
		if (hit)
			deq[m_sel_id] = 1'b1;
		for (int p = 0; p < NP; p++) begin
			m_drop[p] = enq[p] && !deq[p] && (m_cnt[p] == FULL);
			if (enq[p] && !deq[p] && m_cnt[p] < FULL)
				m_cnt[p]++;
			else if (deq[p] && !enq[p])
				m_cnt[p]--;	// Enq with deq holds the count
		end
		if (hit)
			m_gid = m_sel_id;
		else if (m_state == sched_types_pkg::GS_RUN && !m_valid)
			m_gid = 0;	// Wheel stopped
		if (m_valid && !hit)
			m_unused++;	// Wasted slot
		m_grant = deq;
		m_state = m_valid ? sched_types_pkg::GS_RUN : sched_types_pkg::GS_IDLE;
		if (en) begin
			rot_n = (m_rot == sched_cfg_pkg::LAST_ROT) ? 0 : m_rot + 1;
			grp_n = m_grp;
			if (m_rot == sched_cfg_pkg::LAST_ROT)
				grp_n = (m_grp == sched_cfg_pkg::LAST_DMA) ? 0 : m_grp + 1;
			m_sel_id = slot_port(rot_n, grp_n);
			m_sel = '0;
			m_sel[m_sel_id] = 1'b1;
			m_rot = rot_n;
			m_grp = grp_n;
		end
		m_valid = en;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("error: %s %s expected %0d actual %0d (grant unit %s)", test_name, what,
				expected, actual, (m_state == sched_types_pkg::GS_RUN) ? "running" : "idle");
			$display("Test failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Outputs still hold the values of the previous edge here
	always @(posedge clk) begin
		if (!rst_n) begin
			model_reset();
		end else begin
			check_value("grant", 32'(m_grant), 32'(grant));
			check_value("grant_port_id", 32'(m_gid), 32'(grant_port_id));
			check_value("drop", 32'(m_drop), 32'(drop));
			check_value("rot_cnt", 32'(m_rot), 32'(rot_cnt));
			check_value("unused_slots", 32'(m_unused), 32'(unused_slots));
			check_value("sel_port", 32'(m_sel), 32'(dut_i.u_sched.sel_port));
			for (int p = 0; p < NP; p++)
				if (grant[p])
					tally[p]++;
			model_step();
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Simulation timed out before the tests finished");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 32'hb7821c31;
		error_count = 0;
		test_name = "reset";
		rst_n = 1'b0;
		en = 1'b0;
		enq = '0;
		model_reset();
		for (int p = 0; p < NP; p++)
			tally[p] = 0;
		repeat (RST_CYC) @(negedge clk);
		rst_n = 1'b1;

		test_name = "idle_after_reset";	// Everything stays zero with en low
		repeat (IDLE_CYC) @(negedge clk);

		test_name = "full_ports";
		enq = '1;	// Fill every port while the wheel is frozen
		repeat (FILL_CYC) @(negedge clk);
		for (int p = 0; p < NP; p++)
			tally[p] = 0;
		en = 1'b1;
		repeat (FULL_CYC) @(negedge clk);
		en = 1'b0;
		enq = '0;
		repeat (4) @(negedge clk);	// Last grants land two cycles later
		for (int p = 0; p < NP; p++)
			check_value($sformatf("grants to port %0d", p), 32'(2 * per_turn[p]), 32'(tally[p]));

		test_name = "sparse_enqueue";
		en = 1'b1;
		repeat (SPARSE_CYC) begin
			for (int p = 0; p < NP; p++)
				enq[p] = (($random(seed) & 7) == 0);	// About one in eight
			@(negedge clk);
		end

		test_name = "en_toggle";
		repeat (TOGGLE_CYC) begin
			en = (($random(seed) & 3) != 0);
			for (int p = 0; p < NP; p++)
				enq[p] = (($random(seed) & 3) == 0);
			@(negedge clk);
		end

		test_name = "overflow_drop";
		en = 1'b0;	// No slots pending, so OAM saturates
		enq = '0;
		enq[sched_cfg_pkg::OAM_PORT] = 1'b1;
		repeat (20) @(negedge clk);
		en = 1'b1;	// OAM grant meets an enqueue, count holds
		repeat (45) @(negedge clk);
		en = 1'b0;
		enq = '0;
		repeat (8) @(negedge clk);

		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: port_backlog.sv
`timescale 1ns/1ps

module port_backlog #(
	parameter int BACKLOG_W = 4	// Counter width, 2 or more
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] enq,	// Packet arrived
	input  logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] deq,	// Packet granted out

	output wire [sched_cfg_pkg::NUM_OF_PORTS-1:0] nonempty,
	output wire [sched_cfg_pkg::NUM_OF_PORTS-1:0] drop	// Enqueue lost on a full counter
);

	// One saturating counter per port
	for (genvar p = 0; p < sched_cfg_pkg::NUM_OF_PORTS; p++) begin : g_port
		logic [BACKLOG_W-1:0] cnt;
		logic drop_q;
		logic full;

		assign full = &cnt;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt <= '0;
				drop_q <= 1'b0;
			end else begin
				// A deq in the same cycle makes room
				drop_q <= enq[p] & ~deq[p] & full;

				case ({enq[p], deq[p]})
					2'b10: begin
						if (!full)
							cnt <= cnt + 1'b1;	// Saturate at all ones
					end
					2'b01: begin
						if (cnt != '0)
							cnt <= cnt - 1'b1;
					end
					default: cnt <= cnt;	// Both or neither, count holds
				endcase
			end
		end

		assign nonempty[p] = (cnt != '0);	// Seen one cycle after enq
		assign drop[p] = drop_q;
	end

	// The grant unit never pulls from an empty port
	a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(deq & ~nonempty) == '0);

endmodule

// File: port_scheduler.sv
`timescale 1ns/1ps

module port_scheduler (
	input  logic clk,
	input  logic rst_n,
	input  logic en,	// Advances the wheel one slot per cycle

	output logic [1:0] rot_cnt,	// Rotation step of the slot on sel_port
	output logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] sel_port,	// One-hot scheduled port
	output logic [sched_cfg_pkg::PORT_ID_W-1:0] sel_port_id,
	output logic slot_valid	// en one cycle late
);

	localparam int GRP_W = $clog2(sched_cfg_pkg::LAST_DMA + 1);

	logic [GRP_W-1:0] grp_cnt;	// DMA group, 0 to 9

	logic last_rot;
	logic last_grp;
	logic [1:0] rot_nxt;
	logic [GRP_W-1:0] grp_nxt;
	logic [1:0] step;	// Slot kind index, 4 minus rotation
	sched_types_pkg::port_kind_e kind_nxt;
	logic [sched_cfg_pkg::PORT_ID_W-1:0] id_nxt;
	logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] sel_nxt;

	assign last_rot = (rot_cnt == 2'(sched_cfg_pkg::LAST_ROT));
	assign last_grp = (grp_cnt == GRP_W'(sched_cfg_pkg::LAST_DMA));

	// Counters hold while en is low
	assign rot_nxt = en ? (last_rot ? 2'd0 : rot_cnt + 2'd1) : rot_cnt;
	assign grp_nxt = (en && last_rot) ? (last_grp ? '0 : grp_cnt + 1'b1) : grp_cnt;

	assign step = 2'(sched_cfg_pkg::LAST_ROT + 1 - int'(rot_nxt));	// Modulo 4

	// Which kind of port this step feeds
	always_comb begin
		case (step)
			2'd0, 2'd1: kind_nxt = sched_types_pkg::PK_10G;
			2'd2: kind_nxt = sched_types_pkg::PK_DMA;
			default: begin
				// Odd group 9 hands its second DMA slot to OAM
				if (grp_nxt[0] && grp_nxt == GRP_W'(sched_cfg_pkg::LAST_DMA))
					kind_nxt = sched_types_pkg::PK_OAM;
				else
					kind_nxt = sched_types_pkg::PK_DMA;
			end
		endcase
	end

	// Port id within the kind
	always_comb begin
		case (kind_nxt)
			sched_types_pkg::PK_10G: id_nxt = {{(sched_cfg_pkg::PORT_ID_W-1){1'b0}}, step[0]};
			sched_types_pkg::PK_DMA: begin
				if (step == 2'd2)
					id_nxt = grp_nxt[0] ? 3'd3 : 3'd2;	// DMA 0 / DMA 1 alternate
				else
					id_nxt = grp_nxt[0] ? 3'd5 : 3'd4;	// DMA 2 / DMA 3 alternate
			end
			default: id_nxt = sched_cfg_pkg::PORT_ID_W'(sched_cfg_pkg::OAM_PORT);
		endcase
	end

	assign sel_nxt = {{(sched_cfg_pkg::NUM_OF_PORTS-1){1'b0}}, 1'b1} << id_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rot_cnt <= 2'd0;
			grp_cnt <= '0;
			sel_port <= '0;
			sel_port_id <= '0;
			slot_valid <= 1'b0;
		end else begin
			rot_cnt <= rot_nxt;
			grp_cnt <= grp_nxt;
			slot_valid <= en;
			if (en) begin	// Last slot stays visible while frozen
				sel_port <= sel_nxt;
				sel_port_id <= id_nxt;
			end
		end
	end

	// Every valid slot names exactly one port
	a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		slot_valid |-> $onehot(sel_port));

endmodule

// File: sched_cfg_pkg.sv
package sched_cfg_pkg;

	// Egress side of the packet buffer
	// Ports 0 and 1 are 10G
	// Ports 2 to 5 are DMA channels 0 to 3
	// Port 6 is OAM

	localparam int NUM_OF_PORTS = 7;	// Ports served by the wheel

	localparam int PORT_ID_W = 3;	// Binary port id

	// The wheel is 4 rotation steps times 10 groups, 40 slots in all
	localparam int LAST_ROT = 3;	// Rotation counter wraps after this
	localparam int LAST_DMA = 9;	// Group counter wraps after this

	// OAM takes the single odd DMA slot of the last group
	localparam int OAM_PORT = 6;

	// Slots per wheel turn
	// 10G 10 each
	// DMA 0 to 2 5 each, DMA 3 4
	// OAM 1

endpackage

// File: sched_types_pkg.sv
package sched_types_pkg;

	// Kind of port a rotation step serves
	typedef enum logic [1:0] {
		PK_10G,	// Steps 0 and 1
		PK_DMA,	// Steps 2 and 3
		PK_OAM	// Step 3 of the last odd group
	} port_kind_e;

	// Grant unit state
	// Idle until the first valid slot, back to idle when the wheel stops
	typedef enum logic {
		GS_IDLE,
		GS_RUN
	} grant_state_e;

endpackage

// File: slot_grant.sv
`timescale 1ns/1ps

module slot_grant (
	input  logic clk,
	input  logic rst_n,
	input  logic slot_valid,	// Slot on sel_port is live
	input  logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] sel_port,
	input  logic [sched_cfg_pkg::PORT_ID_W-1:0] sel_port_id,
	input  logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] nonempty,	// From the backlog

	output logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] deq,	// Unregistered copy of the grant decision
	output logic [sched_cfg_pkg::NUM_OF_PORTS-1:0] grant,
	output logic [sched_cfg_pkg::PORT_ID_W-1:0] grant_port_id,
	output logic [15:0] unused_slots	// Wraps
);

	sched_types_pkg::grant_state_e state;
	sched_types_pkg::grant_state_e state_nxt;

	logic hit;	// Scheduled port has a packet waiting
	logic wheel_stop;	// Run ends this cycle

	// A live slot is decided on whether the unit is entering or already running
	assign hit = slot_valid & |(sel_port & nonempty);
	assign deq = hit ? sel_port : '0;

	assign wheel_stop = (state == sched_types_pkg::GS_RUN) & ~slot_valid;

	always_comb begin
		state_nxt = state;
		case (state)
			sched_types_pkg::GS_IDLE: begin
				if (slot_valid)
					state_nxt = sched_types_pkg::GS_RUN;	// First valid slot
			end
			sched_types_pkg::GS_RUN: begin
				if (!slot_valid)
					state_nxt = sched_types_pkg::GS_IDLE;	// en dropped
			end
			default: state_nxt = sched_types_pkg::GS_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= sched_types_pkg::GS_IDLE;
			grant <= '0;
			grant_port_id <= '0;
			unused_slots <= 16'd0;
		end else begin
			state <= state_nxt;
			grant <= deq;	// One-cycle pulse

			// Id holds through the run and clears when the wheel stops
			if (hit)
				grant_port_id <= sel_port_id;
			else if (wheel_stop)
				grant_port_id <= '0;

			if (slot_valid && !hit)
				unused_slots <= unused_slots + 16'd1;	// Empty slot wasted
		end
	end

	// At most one port leaves per slot
	a_grant_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant));

endmodule
